//--- Makefile
# Verilator build and run of the cpuCore testbench
VERILATOR ?= verilator
TOP       ?= cpuCoreTb
FILELIST  ?= cpuCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu.sv
// No carry or overflow output; subtraction is B minus A
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word_t  inA,
    input  cpuPkg::word_t  inB,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result,
    output logic           zero
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd:  result = inA + inB;
            // Matches SUBI and R-format SUB operand order
            aluSub:  result = inB - inA;
            aluXor:  result = inA ^ inB;
            aluAndn: result = inA & ~inB;
            aluPassB: result = inB;
            default: result = inB;
        endcase
    end

    // Branch test flag
    assign zero = (result == '0);

endmodule

//--- cpuCore.f
+incdir+.
cpuPkg.sv
alu.sv
ctrlDecode.sv
regFile.sv
instrQueue.sv
instrFetch.sv
execUnit.sv
cpuCore.sv
cpuCoreClk.sv
cpuCoreTb.sv

//--- cpuCore.sv
// Load the program before pulsing start; only reset clears halted
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module cpuCore (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           start,
    input  logic                           progWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] progAddr,
    input  cpuPkg::word_t                  progData,
    output logic                           halted,
    output logic                           retireValid,
    output cpuPkg::word_t                  retirePc,
    output logic                           retireRegWe,
    output cpuPkg::regAddr_t               retireReg,
    output cpuPkg::word_t                  retireData
);
    import cpuPkg::*;

    logic  fetchValid;
    logic  fetchReady;
    word_t fetchPc;
    word_t fetchInstr;
    logic  issueValid;
    logic  issueReady;
    word_t issuePc;
    word_t issueInstr;
    logic  redirect;
    word_t redirectPc;

    // Producer
    instrFetch uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .fetchReady (fetchReady),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .halted     (halted),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr)
    );

    // Redirect drops everything queued behind the branch
    instrQueue uQueue (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (redirect),
        .inValid  (fetchValid),
        .inPc     (fetchPc),
        .inInstr  (fetchInstr),
        .outReady (issueReady),
        .inReady  (fetchReady),
        .outValid (issueValid),
        .outPc    (issuePc),
        .outInstr (issueInstr)
    );

    // Consumer
    execUnit uExec (
        .clk         (clk),
        .rstN        (rstN),
        .issueValid  (issueValid),
        .issuePc     (issuePc),
        .issueInstr  (issueInstr),
        .issueReady  (issueReady),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .halted      (halted),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRegWe (retireRegWe),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

endmodule

//--- cpuCoreClk.sv
// 10 ns free-running clock; reset stays low for 3 rising edges at power-up and after each restart
`timescale 1ns/1ps

module cpuCoreClk (
    input  logic restart,
    output logic clk,
    output logic rstN
);
    logic released = 1'b0;
    int   holdCount = 0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Restart request pulls reset low again
    always @(posedge clk) begin
        if (restart) begin
            released  <= 1'b0;
            holdCount <= 0;
        end else if (!released) begin
            // Third edge releases reset
            if (holdCount == 2) begin
                released <= 1'b1;
            end else begin
                holdCount <= holdCount + 1;
            end
        end
    end

    assign rstN = released;

endmodule

//--- cpuCoreTb.sv
// Directed tests against a reference model; loads each program from address 0 and needs a HALT
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module cpuCoreTb;
    import cpuPkg::*;

    // Roughly 70 program words times 4 cycles plus resets and generous margin
    localparam int cycleLimit     = 2000;
    localparam int modelStepLimit = 200;
    localparam int addrW          = $clog2(`IMEM_DEPTH);
    localparam int memIdxW        = $clog2(`DMEM_DEPTH);

    logic             clk;
    logic             rstN;
    logic             restart;
    logic             start;
    logic             progWe;
    logic [addrW-1:0] progAddr;
    word_t            progData;
    logic             halted;
    logic             retireValid;
    word_t            retirePc;
    logic             retireRegWe;
    regAddr_t         retireReg;
    word_t            retireData;

    int       errors;
    int       checks;
    int       cycles = 0;
    word_t    prog [$];
    word_t    expPc [$];
    logic     expWe [$];
    regAddr_t expReg [$];
    word_t    expData [$];
    word_t    gotPc [$];
    logic     gotWe [$];
    regAddr_t gotReg [$];
    word_t    gotData [$];

    cpuCoreClk clkGen (
        .restart (restart),
        .clk     (clk),
        .rstN    (rstN)
    );

    cpuCore UUT (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .halted      (halted),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRegWe (retireRegWe),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

    // Hard stop if the core never halts
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: no end of tests within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkReg(input string name, input regAddr_t got, input regAddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is R%0d, expected R%0d", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Low bits kept and sign bit copied upward
    function automatic word_t signExtend(input word_t value, input int bits);
        word_t mask;
        mask = ~word_t'(0) << bits;
        return value[bits-1] ? (value | mask) : (value & ~mask);
    endfunction

    // Instruction encoders
    function automatic word_t encR(input regAddr_t rs, input regAddr_t rt,
                                   input regAddr_t rd, input logic [1:0] fn);
        return {opRform, rs, rt, rd, fn};
    endfunction

    function automatic word_t encI(input opcode_t op, input regAddr_t rs,
                                   input regAddr_t rd, input logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic word_t encB(input opcode_t op, input regAddr_t rs, input logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    function automatic word_t encJ(input opcode_t op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    function automatic word_t encHalt();
        return {opHalt, 11'd0};
    endfunction

    // LBI high byte then SLBI low byte
    task automatic loadConst(input regAddr_t r, input word_t value);
        prog.push_back(encB(opLbi, r, value[15:8]));
        prog.push_back(encB(opSlbi, r, value[7:0]));
    endtask

    // Reference ISA model walking the program from pc 0 to HALT
    task automatic modelRun();
        word_t    mRegs [`REG_COUNT];
        word_t    mMem [int];
        word_t    pc;
        word_t    instr;
        word_t    nextPc;
        word_t    value;
        word_t    addr;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        logic     we;
        logic     done;
        int       memKey;
        int       steps;

        expPc.delete();
        expWe.delete();
        expReg.delete();
        expData.delete();
        foreach (mRegs[i]) begin
            mRegs[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < modelStepLimit) begin
            instr  = prog[pc[15:1]];
            rs     = instr[10:8];
            rt     = instr[7:5];
            dest   = rt;
            we     = 1'b0;
            value  = '0;
            nextPc = pc + 16'd2;
            addr   = mRegs[rs] + signExtend(instr, 5);
            memKey = int'(addr[memIdxW:1]);
            case (instr[15:11])
                opRform: begin
                    we   = 1'b1;
                    dest = instr[4:2];
                    case (instr[1:0])
                        2'b00:   value = mRegs[rs] + mRegs[rt];
                        2'b01:   value = mRegs[rt] - mRegs[rs];
                        2'b10:   value = mRegs[rs] ^ mRegs[rt];
                        default: value = mRegs[rs] & ~mRegs[rt];
                    endcase
                end
                opAddi: begin
                    we    = 1'b1;
                    value = mRegs[rs] + signExtend(instr, 5);
                end
                opSubi: begin
                    we    = 1'b1;
                    value = signExtend(instr, 5) - mRegs[rs];
                end
                opLbi: begin
                    we    = 1'b1;
                    dest  = rs;
                    value = signExtend(instr, 8);
                end
                opSlbi: begin
                    we    = 1'b1;
                    dest  = rs;
                    value = (mRegs[rs] << 8) | {8'h00, instr[7:0]};
                end
                opLd: begin
                    we    = 1'b1;
                    value = mMem.exists(memKey) ? mMem[memKey] : '0;
                end
                opSt: mMem[memKey] = mRegs[rt];
                opBeqz: begin
                    if (mRegs[rs] == '0) begin
                        nextPc = pc + 16'd2 + signExtend(instr, 8);
                    end
                end
                opBnez: begin
                    if (mRegs[rs] != '0) begin
                        nextPc = pc + 16'd2 + signExtend(instr, 8);
                    end
                end
                opJ: nextPc = pc + 16'd2 + signExtend(instr, 11);
                opJal: begin
                    we     = 1'b1;
                    dest   = regAddr_t'(`REG_COUNT - 1);
                    value  = pc + 16'd2;
                    nextPc = pc + 16'd2 + signExtend(instr, 11);
                end
                opHalt: done = 1'b1;
                default: ;
            endcase
            if (we) begin
                mRegs[dest] = value;
            end
            expPc.push_back(pc);
            expWe.push_back(we);
            expReg.push_back(dest);
            expData.push_back(value);
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic resetCore();
        restart = 1'b1;
        @(posedge clk);
        #1;
        restart = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!rstN);
    endtask

    task automatic loadAndStart();
        for (int i = 0; i < prog.size(); i++) begin
            progWe   = 1'b1;
            progAddr = addrW'(i);
            progData = prog[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // Retire records up to and including HALT
    task automatic collectRetires();
        gotPc.delete();
        gotWe.delete();
        gotReg.delete();
        gotData.delete();
        while (!halted) begin
            @(posedge clk);
            #1;
            if (retireValid) begin
                gotPc.push_back(retirePc);
                gotWe.push_back(retireRegWe);
                gotReg.push_back(retireReg);
                gotData.push_back(retireData);
            end
        end
    endtask

    task automatic compareRetires(input string testName);
        int n;
        checks++;
        if (gotPc.size() != expPc.size()) begin
            errors++;
            $display("%s: core retired %0d instructions but %0d were expected",
                     testName, gotPc.size(), expPc.size());
        end
        n = (gotPc.size() < expPc.size()) ? gotPc.size() : expPc.size();
        for (int i = 0; i < n; i++) begin
            checkWord($sformatf("%s retirePc[%0d]", testName, i), gotPc[i], expPc[i]);
            checkBit($sformatf("%s retireRegWe[%0d]", testName, i), gotWe[i], expWe[i]);
            // Register and data only mean something on a write
            if (expWe[i]) begin
                checkReg($sformatf("%s retireReg[%0d]", testName, i), gotReg[i], expReg[i]);
                checkWord($sformatf("%s retireData[%0d]", testName, i), gotData[i], expData[i]);
            end
        end
    endtask

    task automatic runProgram(input string testName);
        resetCore();
        loadAndStart();
        modelRun();
        collectRetires();
        compareRetires(testName);
    endtask

    task automatic testAluOps();
        prog.delete();
        loadConst(3'd1, word_t'($urandom));
        loadConst(3'd2, word_t'($urandom));
        prog.push_back(encR(3'd1, 3'd2, 3'd3, 2'b00));
        prog.push_back(encR(3'd1, 3'd2, 3'd4, 2'b01));
        prog.push_back(encR(3'd1, 3'd2, 3'd5, 2'b10));
        prog.push_back(encR(3'd1, 3'd2, 3'd6, 2'b11));
        // Swapped operands for the order-dependent ops
        prog.push_back(encR(3'd2, 3'd1, 3'd7, 2'b01));
        prog.push_back(encR(3'd2, 3'd1, 3'd0, 2'b11));
        prog.push_back(encHalt());
        runProgram("aluOps");
    endtask

    task automatic testImmediates();
        word_t negByte;
        word_t posByte;
        negByte = word_t'($urandom) | 16'h0080;
        posByte = word_t'($urandom) & 16'h007f;
        prog.delete();
        prog.push_back(encB(opLbi, 3'd1, negByte[7:0]));
        prog.push_back(encB(opLbi, 3'd2, posByte[7:0]));
        // imm5 of -5, 7, -3, 9 and -16
        prog.push_back(encI(opAddi, 3'd1, 3'd3, 5'b11011));
        prog.push_back(encI(opAddi, 3'd2, 3'd4, 5'd7));
        prog.push_back(encI(opSubi, 3'd2, 3'd5, 5'b11101));
        prog.push_back(encI(opSubi, 3'd1, 3'd6, 5'd9));
        prog.push_back(encI(opAddi, 3'd0, 3'd7, 5'b10000));
        prog.push_back(encHalt());
        runProgram("immediates");
    endtask

    task automatic testLoadStore();
        prog.delete();
        loadConst(3'd1, word_t'($urandom));
        loadConst(3'd2, word_t'($urandom));
        loadConst(3'd3, word_t'($urandom));
        prog.push_back(encI(opSt, 3'd0, 3'd1, 5'd4));
        prog.push_back(encI(opSt, 3'd0, 3'd2, 5'd10));
        // Negative offset wraps to the top of the address space
        prog.push_back(encI(opSt, 3'd0, 3'd3, 5'b11000));
        prog.push_back(encB(opLbi, 3'd7, 8'h40));
        prog.push_back(encI(opSt, 3'd7, 3'd2, 5'b11110));
        prog.push_back(encI(opLd, 3'd0, 3'd4, 5'd4));
        prog.push_back(encI(opLd, 3'd0, 3'd5, 5'd10));
        prog.push_back(encI(opLd, 3'd0, 3'd6, 5'b11000));
        prog.push_back(encI(opLd, 3'd7, 3'd1, 5'b11110));
        prog.push_back(encHalt());
        runProgram("loadStore");
    endtask

    task automatic testBranches();
        prog.delete();
        prog.push_back(encB(opLbi, 3'd1, 8'h00));
        prog.push_back(encB(opLbi, 3'd2, 8'h05));
        // Taken BEQZ skips pc 6
        prog.push_back(encB(opBeqz, 3'd1, 8'd2));
        prog.push_back(encB(opLbi, 3'd3, 8'h11));
        prog.push_back(encB(opBnez, 3'd1, 8'd2));
        prog.push_back(encB(opLbi, 3'd3, 8'h22));
        // Taken BNEZ skips two
        prog.push_back(encB(opBnez, 3'd2, 8'd4));
        prog.push_back(encB(opLbi, 3'd4, 8'h33));
        prog.push_back(encB(opLbi, 3'd4, 8'h44));
        prog.push_back(encB(opBeqz, 3'd2, 8'd2));
        prog.push_back(encB(opLbi, 3'd5, 8'h55));
        // Backward loop of three passes
        prog.push_back(encB(opLbi, 3'd6, 8'h03));
        prog.push_back(encI(opAddi, 3'd6, 3'd6, 5'b11111));
        prog.push_back(encB(opBnez, 3'd6, 8'hfc));
        prog.push_back(encHalt());
        runProgram("branches");
    endtask

    task automatic testJumps();
        prog.delete();
        prog.push_back(encJ(opJ, 11'd6));
        prog.push_back(encB(opLbi, 3'd1, 8'h11));
        prog.push_back(encJ(opJal, 11'd8));
        prog.push_back(encB(opLbi, 3'd1, 8'h66));
        prog.push_back(encB(opLbi, 3'd2, 8'h22));
        // Backward JAL to pc 4
        prog.push_back(encJ(opJal, 11'h7f8));
        prog.push_back(encB(opLbi, 3'd3, 8'h33));
        prog.push_back(encB(opLbi, 3'd4, 8'h44));
        // Forward J skips the HALT at pc 18 that the backward J then reaches
        prog.push_back(encJ(opJ, 11'd2));
        prog.push_back(encHalt());
        prog.push_back(encJ(opJ, 11'h7fc));
        runProgram("jumps");
    endtask

    task automatic testHaltHold();
        prog.delete();
        loadConst(3'd1, word_t'($urandom));
        prog.push_back(encHalt());
        // Words behind HALT that must never retire
        for (int i = 0; i < 6; i++) begin
            prog.push_back(encB(opLbi, 3'd2, 8'(i + 1)));
        end
        runProgram("haltHold");
        repeat (20) begin
            @(posedge clk);
            #1;
            checkBit("retireValid after halt", retireValid, 1'b0);
            checkBit("halted", halted, 1'b1);
        end
    endtask

    initial begin
        restart  = 1'b0;
        start    = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        errors   = 0;
        checks   = 0;
        void'($urandom(32'hcd32_7081));
        testAluOps();
        testImmediates();
        testLoadStore();
        testBranches();
        testJumps();
        testHaltHold();
        $display("Ran %0d checks with %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- cpuCore_macros.svh
// Sizes shared by RTL and testbench; QUEUE_DEPTH must be at least 2 and both memories hold words
`ifndef CPU_CORE_MACROS_SVH
`define CPU_CORE_MACROS_SVH

// Datapath word width in bits
`define DATA_WIDTH 16

// Architectural registers, R7 doubles as link register
`define REG_COUNT 8

// Instruction memory size in 16-bit words
`define IMEM_DEPTH 256

// Data memory size in 16-bit words
`define DMEM_DEPTH 256

// Entries between fetch and execute
`define QUEUE_DEPTH 4

`endif

//--- cpuPkg.sv
// Encodings assume 16-bit instructions with the opcode in bits 15 to 11 and eight registers
`include "cpuCore_macros.svh"

package cpuPkg;

    // Data and byte address word
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // Register index
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

    // JAL target register
    localparam regAddr_t linkReg = regAddr_t'(`REG_COUNT - 1);

    // Opcode field, instr[15:11]
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJal   = 5'b00110,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opLbi   = 5'b11000,
        opRform = 5'b11011
    } opcode_t;

    // SUB is B minus A, ANDN is A and not B
    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluXor   = 3'd2,
        aluAndn  = 3'd3,
        aluPassB = 3'd4
    } aluOp_t;

    // Decoded control for one instruction
    typedef struct packed {
        logic     regWrite;
        regAddr_t writeReg;
        aluOp_t   aluOp;
        logic     aluSrcImm;
        word_t    imm;
        logic     memRead;
        logic     memWrite;
        logic     branchZ;
        logic     branchNz;
        logic     jump;
        logic     link;
        logic     shiftLoad;
        logic     halt;
    } ctrl_t;

endpackage

//--- ctrlDecode.sv
// Purely combinational; any opcode outside the listed set decodes as NOP
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module ctrlDecode (
    input  cpuPkg::word_t instr,
    output cpuPkg::ctrl_t ctrl
);
    import cpuPkg::*;

    opcode_t opcode;
    word_t   imm5S;
    word_t   imm8S;
    word_t   imm8Z;
    word_t   disp11S;

    assign opcode = opcode_t'(instr[15:11]);

    // Immediate forms
    assign imm5S   = {{(`DATA_WIDTH - 5){instr[4]}}, instr[4:0]};
    assign imm8S   = {{(`DATA_WIDTH - 8){instr[7]}}, instr[7:0]};
    assign imm8Z   = {{(`DATA_WIDTH - 8){1'b0}}, instr[7:0]};
    assign disp11S = {{(`DATA_WIDTH - 11){instr[10]}}, instr[10:0]};

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        case (opcode)
            opHalt: ctrl.halt = 1'b1;
            opJ: begin
                ctrl.jump = 1'b1;
                ctrl.imm  = disp11S;
            end
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeReg = linkReg;
                ctrl.imm      = disp11S;
            end
            opAddi, opSubi, opLd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.writeReg  = instr[7:5];
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = imm5S;
                // SUBI yields imm minus rs
                ctrl.aluOp     = (opcode == opSubi) ? aluSub : aluAdd;
                ctrl.memRead   = (opcode == opLd);
            end
            opSt: begin
                // Address is rs + imm5 and data comes from the rd field
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = imm5S;
            end
            opBeqz, opBnez: begin
                ctrl.branchZ  = (opcode == opBeqz);
                ctrl.branchNz = (opcode == opBnez);
                ctrl.imm      = imm8S;
            end
            opSlbi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.writeReg  = instr[10:8];
                ctrl.shiftLoad = 1'b1;
                ctrl.imm       = imm8Z;
            end
            opLbi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.writeReg  = instr[10:8];
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
                ctrl.imm       = imm8S;
            end
            opRform: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeReg = instr[4:2];
                // Function field picks the operation
                case (instr[1:0])
                    2'b00:   ctrl.aluOp = aluAdd;
                    2'b01:   ctrl.aluOp = aluSub;
                    2'b10:   ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluAndn;
                endcase
            end
            // Unlisted opcodes behave as NOP
            default: ;
        endcase
    end

endmodule

//--- execUnit.sv
// One instruction per cycle with no stalls before HALT; data memory is word aligned by address bit 0
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module execUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             issueValid,
    input  cpuPkg::word_t    issuePc,
    input  cpuPkg::word_t    issueInstr,
    output logic             issueReady,
    output logic             redirect,
    output cpuPkg::word_t    redirectPc,
    output logic             halted,
    output logic             retireValid,
    output cpuPkg::word_t    retirePc,
    output logic             retireRegWe,
    output cpuPkg::regAddr_t retireReg,
    output cpuPkg::word_t    retireData
);
    import cpuPkg::*;

    localparam int dIdxW = $clog2(`DMEM_DEPTH);

    ctrl_t            ctrl;
    word_t            rsData;
    word_t            rtData;
    word_t            aluInB;
    word_t            aluResult;
    logic             aluZero;
    word_t            pcPlus2;
    word_t            memData;
    word_t            slbiValue;
    word_t            wbData;
    logic [dIdxW-1:0] memIdx;
    logic             fire;
    logic             taken;
    word_t            dmem [`DMEM_DEPTH];

    ctrlDecode uDecode (
        .instr (issueInstr),
        .ctrl  (ctrl)
    );

    // rs at 10:8, rt and I-format rd at 7:5
    regFile uRegs (
        .clk       (clk),
        .rstN      (rstN),
        .readAddr1 (issueInstr[10:8]),
        .readAddr2 (issueInstr[7:5]),
        .writeEn   (fire && ctrl.regWrite),
        .writeAddr (ctrl.writeReg),
        .writeData (wbData),
        .readData1 (rsData),
        .readData2 (rtData)
    );

    // Branches pass rs through so the zero flag tests it
    assign aluInB = (ctrl.branchZ || ctrl.branchNz) ? '0 :
                    ctrl.aluSrcImm ? ctrl.imm : rtData;

    alu uAlu (
        .inA    (rsData),
        .inB    (aluInB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign issueReady = !halted;
    assign fire       = issueValid && issueReady;
    assign pcPlus2    = issuePc + word_t'(2);

    // Taken branch or jump
    assign taken      = ctrl.jump || (ctrl.branchZ && aluZero) || (ctrl.branchNz && !aluZero);
    assign redirect   = fire && taken;
    assign redirectPc = pcPlus2 + ctrl.imm;

    // Data memory at rs + imm5
    assign memIdx  = aluResult[dIdxW:1];
    assign memData = dmem[memIdx];

    always_ff @(posedge clk) begin
        if (fire && ctrl.memWrite) begin
            dmem[memIdx] <= rtData;
        end
    end

    // SLBI keeps low byte of rs as high byte
    assign slbiValue = (rsData << 8) | ctrl.imm;

    always_comb begin
        if (ctrl.link) begin
            wbData = pcPlus2;
        end else if (ctrl.memRead) begin
            wbData = memData;
        end else if (ctrl.shiftLoad) begin
            wbData = slbiValue;
        end else begin
            wbData = aluResult;
        end
    end

    // Halt is sticky until reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted      <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            retireValid <= fire;
            if (fire && ctrl.halt) begin
                halted <= 1'b1;
            end
        end
    end

    // Retire record, one cycle after the pop
    always_ff @(posedge clk) begin
        if (fire) begin
            retirePc    <= issuePc;
            retireRegWe <= ctrl.regWrite;
            retireReg   <= ctrl.writeReg;
            retireData  <= wbData;
        end
    end

endmodule

//--- instrFetch.sv
// Program loading is ignored once start has been seen; instruction memory reads combinationally
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module instrFetch (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           start,
    input  logic                           progWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] progAddr,
    input  cpuPkg::word_t                  progData,
    input  logic                           fetchReady,
    input  logic                           redirect,
    input  cpuPkg::word_t                  redirectPc,
    input  logic                           halted,
    output logic                           fetchValid,
    output cpuPkg::word_t                  fetchPc,
    output cpuPkg::word_t                  fetchInstr
);
    import cpuPkg::*;

    localparam int idxW = $clog2(`IMEM_DEPTH);

    word_t imem [`IMEM_DEPTH];
    word_t pc;
    logic  running;

    // Load port, closed after start
    always_ff @(posedge clk) begin
        if (progWe && !running) begin
            imem[progAddr] <= progData;
        end
    end

    // Pc update, redirect beats sequential advance
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            pc      <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                pc      <= '0;
            end else if (redirect) begin
                pc <= redirectPc;
            end else if (fetchValid && fetchReady) begin
                pc <= pc + word_t'(2);
            end
        end
    end

    // Offer word at pc until accepted
    assign fetchValid = running && !halted;
    assign fetchPc    = pc;
    // Word index from byte pc
    assign fetchInstr = imem[pc[idxW:1]];

endmodule

//--- instrQueue.sv
// Flush wins over a same-cycle push; depth need not be a power of two
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module instrQueue (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    input  logic          inValid,
    input  cpuPkg::word_t inPc,
    input  cpuPkg::word_t inInstr,
    input  logic          outReady,
    output logic          inReady,
    output logic          outValid,
    output cpuPkg::word_t outPc,
    output cpuPkg::word_t outInstr
);
    import cpuPkg::*;

    localparam int ptrW = $clog2(`QUEUE_DEPTH);

    word_t            pcMem    [`QUEUE_DEPTH];
    word_t            instrMem [`QUEUE_DEPTH];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [ptrW:0]    count;
    logic             push;
    logic             pop;

    // Circular pointer step
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(`QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign inReady  = (count != (ptrW + 1)'(`QUEUE_DEPTH));
    assign outValid = (count != '0);
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            pcMem[wrPtr]    <= inPc;
            instrMem[wrPtr] <= inInstr;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop keeps count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry
    assign outPc    = pcMem[rdPtr];
    assign outInstr = instrMem[rdPtr];

endmodule

//--- regFile.sv
// Reads are combinational with no write bypass; R0 is an ordinary writable register
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::regAddr_t readAddr1,
    input  cpuPkg::regAddr_t readAddr2,
    input  logic             writeEn,
    input  cpuPkg::regAddr_t writeAddr,
    input  cpuPkg::word_t    writeData,
    output cpuPkg::word_t    readData1,
    output cpuPkg::word_t    readData2
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    // All registers start at zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule
